//--- design/pck_memory_map.sv
// ##########################################################
// memory map package
// region bases and masks of the peripheral bus, decoded
// region ids, bridge states and register word offsets
// ##########################################################
`default_nettype none

package pck_memory_map;

  // decoded target of a bus request
  typedef enum logic [1:0] {
    DMEM_ID,
    GPIO_ID,
    TIMER_ID,
    NO_PERIPH
  } region_e;

  // bridge transaction fsm
  typedef enum logic {
    IDLE,
    WAIT
  } bridge_state_e;

  localparam pck_soc_bus::addr_t DMEM_ADDR       = 32'h1000_0000;
  localparam pck_soc_bus::addr_t DMEM_ADDR_MASK  = 32'hFFFF_F000;   // 4 KiB window
  localparam pck_soc_bus::addr_t GPIO_ADDR       = 32'h2000_0000;
  localparam pck_soc_bus::addr_t GPIO_ADDR_MASK  = 32'hFFFF_FF00;   // 256 B window
  localparam pck_soc_bus::addr_t TIMER_ADDR      = 32'h3000_0000;
  localparam pck_soc_bus::addr_t TIMER_ADDR_MASK = 32'hFFFF_FF00;   // 256 B window

  // gpio register word offsets
  localparam pck_soc_bus::reg_addr_t GPIO_OUT_OFS = 6'd0;
  localparam pck_soc_bus::reg_addr_t GPIO_OE_OFS  = 6'd1;
  localparam pck_soc_bus::reg_addr_t GPIO_PU_OFS  = 6'd2;
  localparam pck_soc_bus::reg_addr_t GPIO_PD_OFS  = 6'd3;
  localparam pck_soc_bus::reg_addr_t GPIO_IN_OFS  = 6'd4;   // read only

  // cycle counter word offsets
  localparam pck_soc_bus::reg_addr_t TIMER_LO_OFS = 6'd0;
  localparam pck_soc_bus::reg_addr_t TIMER_HI_OFS = 6'd1;

  localparam pck_soc_bus::data_t UNMAPPED_RD_DATA = 32'h0000_0000;

endpackage

`default_nettype wire

//--- design/pck_soc_bus.sv
// ##########################################################
// data bus package
// widths and vector types of the peripheral data bus,
// the GPIO pin vector and the data memory index
// ##########################################################
`default_nettype none

package pck_soc_bus;

  localparam int NUM_GPIOS      = 24;   // gpio pins on the block
  localparam int DMEM_DEPTH_PW2 = 10;   // 1024 words of data memory

  // byte address on the data bus
  typedef logic [31:0] addr_t;

  // one bus data word
  typedef logic [31:0] data_t;

  // write byte enables, one per lane
  typedef logic [3:0] be_t;

  // one bit per gpio pin
  typedef logic [NUM_GPIOS-1:0] gpio_t;

  // word index into the data memory
  typedef logic [DMEM_DEPTH_PW2-1:0] dmem_addr_t;

  // word offset inside a 256 byte peripheral window
  typedef logic [5:0] reg_addr_t;

endpackage

`default_nettype wire

//--- design/perif_gpio.sv
// ##########################################################
// gpio block
// output, output enable, pull-up and pull-down registers
// with byte-enable writes, plus a synchronized input
// register, all mapped as words on the data bus
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module perif_gpio (
  input  wire                       i_clk,
  input  wire                       i_arst_n,
  input  wire                       i_req,
  input  wire                       i_wr,
  input  wire pck_soc_bus::reg_addr_t i_addr,
  input  wire pck_soc_bus::be_t     i_be,
  input  wire pck_soc_bus::data_t   i_wr_data,
  input  wire pck_soc_bus::gpio_t   i_gpio_in,
  output pck_soc_bus::data_t        o_rd_data,
  output logic                      o_ack,
  output pck_soc_bus::gpio_t        o_gpio_out,
  output pck_soc_bus::gpio_t        o_gpio_out_en,
  output pck_soc_bus::gpio_t        o_gpio_pullup,
  output pck_soc_bus::gpio_t        o_gpio_pulldown
);

  import pck_soc_bus::*;
  import pck_memory_map::*;

  gpio_t sync_meta_q;   // first synchronizer stage
  gpio_t sync_in_q;     // stable pin value
  logic  wr_req;

  // merge enabled byte lanes of the write into a register
  function automatic gpio_t merge_be(gpio_t old_val, data_t wr_data, be_t be);
    data_t mask;
    for (int lane = 0; lane < $bits(be_t); lane++) begin
      mask[8*lane +: 8] = {8{be[lane]}};
    end
    return gpio_t'((data_t'(old_val) & ~mask) | (wr_data & mask));
  endfunction

  assign wr_req = i_req && i_wr;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_gpio_out      <= '0;
      o_gpio_out_en   <= '0;
      o_gpio_pullup   <= '0;
      o_gpio_pulldown <= '0;
    end else if (wr_req) begin
      case (i_addr)
        GPIO_OUT_OFS: o_gpio_out      <= merge_be(o_gpio_out, i_wr_data, i_be);
        GPIO_OE_OFS:  o_gpio_out_en   <= merge_be(o_gpio_out_en, i_wr_data, i_be);
        GPIO_PU_OFS:  o_gpio_pullup   <= merge_be(o_gpio_pullup, i_wr_data, i_be);
        GPIO_PD_OFS:  o_gpio_pulldown <= merge_be(o_gpio_pulldown, i_wr_data, i_be);
        default: ;   // gpio_in and holes ignore writes
      endcase
    end
  end

  // two flop input synchronizer
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      sync_meta_q <= '0;
      sync_in_q   <= '0;
    end else begin
      sync_meta_q <= i_gpio_in;
      sync_in_q   <= sync_meta_q;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_req && !i_wr) begin
      case (i_addr)
        GPIO_OUT_OFS: o_rd_data <= data_t'(o_gpio_out);
        GPIO_OE_OFS:  o_rd_data <= data_t'(o_gpio_out_en);
        GPIO_PU_OFS:  o_rd_data <= data_t'(o_gpio_pullup);
        GPIO_PD_OFS:  o_rd_data <= data_t'(o_gpio_pulldown);
        GPIO_IN_OFS:  o_rd_data <= data_t'(sync_in_q);
        default:      o_rd_data <= '0;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ack <= 1'b0;
    end else begin
      o_ack <= i_req;
    end
  end

endmodule

`default_nettype wire

//--- design/soc_bridge.sv
// ##########################################################
// data bus bridge
// decodes the master address into one of three slaves,
// forwards the request and returns ack and read data one
// cycle later, answering unmapped accesses itself
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module soc_bridge (
  input  wire                       i_clk,
  input  wire                       i_arst_n,
  // master side
  input  wire pck_soc_bus::addr_t   i_dbus_addr,
  input  wire pck_soc_bus::be_t     i_dbus_be,
  input  wire                       i_dbus_wr_en,
  input  wire pck_soc_bus::data_t   i_dbus_wr_data,
  input  wire                       i_dbus_rd_en,
  output pck_soc_bus::data_t        o_dbus_rd_data,
  output logic                      o_dbus_busy,
  output logic                      o_dbus_ack,
  // slave side
  output logic                      o_dmem_req,
  output pck_soc_bus::dmem_addr_t   o_dmem_addr,
  input  wire pck_soc_bus::data_t   i_dmem_rd_data,
  input  wire                       i_dmem_ack,
  output logic                      o_gpio_req,
  output pck_soc_bus::reg_addr_t    o_gpio_addr,
  input  wire pck_soc_bus::data_t   i_gpio_rd_data,
  input  wire                       i_gpio_ack,
  output logic                      o_timer_req,
  output pck_soc_bus::reg_addr_t    o_timer_addr,
  input  wire pck_soc_bus::data_t   i_timer_rd_data,
  input  wire                       i_timer_ack,
  output logic                      o_wr,
  output pck_soc_bus::be_t          o_be,
  output pck_soc_bus::data_t        o_wr_data
);

  import pck_soc_bus::*;
  import pck_memory_map::*;

  bridge_state_e state_q;
  region_e       region;     // decode of the current address
  region_e       region_q;   // target of the transaction in flight
  logic          accept;

  // requests are taken only in idle
  assign accept = (i_dbus_rd_en || i_dbus_wr_en) && (state_q == IDLE);

  always_comb begin
    if ((i_dbus_addr & DMEM_ADDR_MASK) == DMEM_ADDR) begin
      region = DMEM_ID;
    end else if ((i_dbus_addr & GPIO_ADDR_MASK) == GPIO_ADDR) begin
      region = GPIO_ID;
    end else if ((i_dbus_addr & TIMER_ADDR_MASK) == TIMER_ADDR) begin
      region = TIMER_ID;
    end else begin
      region = NO_PERIPH;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q  <= IDLE;
      region_q <= NO_PERIPH;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q  <= WAIT;
            region_q <= region;   // held for the response cycle
          end
        end
        default: state_q <= IDLE;   // wait lasts one cycle
      endcase
    end
  end

  // request fan-out
  assign o_dmem_req   = accept && (region == DMEM_ID);
  assign o_gpio_req   = accept && (region == GPIO_ID);
  assign o_timer_req  = accept && (region == TIMER_ID);
  assign o_dmem_addr  = i_dbus_addr[DMEM_DEPTH_PW2+1:2];
  assign o_gpio_addr  = i_dbus_addr[$bits(reg_addr_t)+1:2];
  assign o_timer_addr = i_dbus_addr[$bits(reg_addr_t)+1:2];
  assign o_wr         = i_dbus_wr_en;
  assign o_be         = i_dbus_be;
  assign o_wr_data    = i_dbus_wr_data;

  // response return path
  always_comb begin
    case (region_q)
      DMEM_ID: begin
        o_dbus_rd_data = i_dmem_rd_data;
        o_dbus_ack     = (state_q == WAIT) && i_dmem_ack;
      end
      GPIO_ID: begin
        o_dbus_rd_data = i_gpio_rd_data;
        o_dbus_ack     = (state_q == WAIT) && i_gpio_ack;
      end
      TIMER_ID: begin
        o_dbus_rd_data = i_timer_rd_data;
        o_dbus_ack     = (state_q == WAIT) && i_timer_ack;
      end
      default: begin
        o_dbus_rd_data = UNMAPPED_RD_DATA;
        o_dbus_ack     = (state_q == WAIT);   // bridge answers itself
      end
    endcase
  end

  assign o_dbus_busy = (state_q == WAIT);

endmodule

`default_nettype wire

//--- design/soc_cycle_counter.sv
// ##########################################################
// cycle counter slave
// free-running 64-bit count of clock cycles, read as two
// words with the high word latched on the low word read
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module soc_cycle_counter (
  input  wire                       i_clk,
  input  wire                       i_arst_n,
  input  wire                       i_req,
  input  wire                       i_wr,
  input  wire pck_soc_bus::reg_addr_t i_addr,
  output pck_soc_bus::data_t        o_rd_data,
  output logic                      o_ack
);

  import pck_soc_bus::*;
  import pck_memory_map::*;

  logic [63:0] count_q;
  data_t       hi_snap_q;   // upper word at the last low read

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      count_q <= '0;
      o_ack   <= 1'b0;
    end else begin
      count_q <= count_q + 64'd1;
      o_ack   <= i_req;   // writes are acked too
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_req && !i_wr) begin
      case (i_addr)
        TIMER_LO_OFS: begin
          o_rd_data <= count_q[31:0];
          hi_snap_q <= count_q[63:32];
        end
        TIMER_HI_OFS: o_rd_data <= hi_snap_q;
        default:      o_rd_data <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/soc_dmem.sv
// ##########################################################
// data memory
// single-port word memory with byte-lane writes and a
// registered read port, acked one cycle after request
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module soc_dmem (
  input  wire                         i_clk,
  input  wire                         i_arst_n,
  input  wire                         i_req,
  input  wire                         i_wr,
  input  wire pck_soc_bus::dmem_addr_t i_addr,
  input  wire pck_soc_bus::be_t       i_be,
  input  wire pck_soc_bus::data_t     i_wr_data,
  output pck_soc_bus::data_t          o_rd_data,
  output logic                        o_ack
);

  import pck_soc_bus::*;

  localparam int NUM_LANES = $bits(be_t);
  localparam int DEPTH     = 2 ** DMEM_DEPTH_PW2;

  data_t mem [DEPTH];

  // byte lane writes
  always_ff @(posedge i_clk) begin
    if (i_req && i_wr) begin
      for (int lane = 0; lane < NUM_LANES; lane++) begin
        if (i_be[lane]) begin
          mem[i_addr][8*lane +: 8] <= i_wr_data[8*lane +: 8];
        end
      end
    end
  end

  // read port keeps its old word across writes
  always_ff @(posedge i_clk) begin
    if (i_req && !i_wr) begin
      o_rd_data <= mem[i_addr];
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ack <= 1'b0;
    end else begin
      o_ack <= i_req;
    end
  end

endmodule

`default_nettype wire

//--- design/soc_periph.sv
// ##########################################################
// peripheral subsystem top
// data bus bridge with data memory, gpio block and
// cycle counter behind it
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module soc_periph (
  input  wire                       i_clk,
  input  wire                       i_arst_n,
  // data bus
  input  wire pck_soc_bus::addr_t   i_dbus_addr,
  input  wire pck_soc_bus::be_t     i_dbus_be,
  input  wire                       i_dbus_wr_en,
  input  wire pck_soc_bus::data_t   i_dbus_wr_data,
  input  wire                       i_dbus_rd_en,
  output wire pck_soc_bus::data_t   o_dbus_rd_data,
  output wire                       o_dbus_busy,
  output wire                       o_dbus_ack,
  // gpio pins
  input  wire pck_soc_bus::gpio_t   i_gpio_in,
  output wire pck_soc_bus::gpio_t   o_gpio_out,
  output wire pck_soc_bus::gpio_t   o_gpio_out_en,
  output wire pck_soc_bus::gpio_t   o_gpio_pullup,
  output wire pck_soc_bus::gpio_t   o_gpio_pulldown
);

  import pck_soc_bus::*;

  wire             dmem_req;
  wire dmem_addr_t dmem_addr;
  wire data_t      dmem_rd_data;
  wire             dmem_ack;
  wire             gpio_req;
  wire reg_addr_t  gpio_addr;
  wire data_t      gpio_rd_data;
  wire             gpio_ack;
  wire             timer_req;
  wire reg_addr_t  timer_addr;
  wire data_t      timer_rd_data;
  wire             timer_ack;
  wire             slv_wr;        // shared by all slaves
  wire be_t        slv_be;
  wire data_t      slv_wr_data;

  soc_bridge u_bridge (
    .i_clk           ( i_clk          ),
    .i_arst_n        ( i_arst_n       ),
    .i_dbus_addr     ( i_dbus_addr    ),
    .i_dbus_be       ( i_dbus_be      ),
    .i_dbus_wr_en    ( i_dbus_wr_en   ),
    .i_dbus_wr_data  ( i_dbus_wr_data ),
    .i_dbus_rd_en    ( i_dbus_rd_en   ),
    .o_dbus_rd_data  ( o_dbus_rd_data ),
    .o_dbus_busy     ( o_dbus_busy    ),
    .o_dbus_ack      ( o_dbus_ack     ),
    .o_dmem_req      ( dmem_req       ),
    .o_dmem_addr     ( dmem_addr      ),
    .i_dmem_rd_data  ( dmem_rd_data   ),
    .i_dmem_ack      ( dmem_ack       ),
    .o_gpio_req      ( gpio_req       ),
    .o_gpio_addr     ( gpio_addr      ),
    .i_gpio_rd_data  ( gpio_rd_data   ),
    .i_gpio_ack      ( gpio_ack       ),
    .o_timer_req     ( timer_req      ),
    .o_timer_addr    ( timer_addr     ),
    .i_timer_rd_data ( timer_rd_data  ),
    .i_timer_ack     ( timer_ack      ),
    .o_wr            ( slv_wr         ),
    .o_be            ( slv_be         ),
    .o_wr_data       ( slv_wr_data    )
  );

  soc_dmem u_dmem (
    .i_clk     ( i_clk        ),
    .i_arst_n  ( i_arst_n     ),
    .i_req     ( dmem_req     ),
    .i_wr      ( slv_wr       ),
    .i_addr    ( dmem_addr    ),
    .i_be      ( slv_be       ),
    .i_wr_data ( slv_wr_data  ),
    .o_rd_data ( dmem_rd_data ),
    .o_ack     ( dmem_ack     )
  );

  perif_gpio u_gpio (
    .i_clk           ( i_clk           ),
    .i_arst_n        ( i_arst_n        ),
    .i_req           ( gpio_req        ),
    .i_wr            ( slv_wr          ),
    .i_addr          ( gpio_addr       ),
    .i_be            ( slv_be          ),
    .i_wr_data       ( slv_wr_data     ),
    .i_gpio_in       ( i_gpio_in       ),
    .o_rd_data       ( gpio_rd_data    ),
    .o_ack           ( gpio_ack        ),
    .o_gpio_out      ( o_gpio_out      ),
    .o_gpio_out_en   ( o_gpio_out_en   ),
    .o_gpio_pullup   ( o_gpio_pullup   ),
    .o_gpio_pulldown ( o_gpio_pulldown )
  );

  soc_cycle_counter u_cycle_counter (
    .i_clk     ( i_clk         ),
    .i_arst_n  ( i_arst_n      ),
    .i_req     ( timer_req     ),
    .i_wr      ( slv_wr        ),
    .i_addr    ( timer_addr    ),
    .o_rd_data ( timer_rd_data ),
    .o_ack     ( timer_ack     )
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
  --top-module tb_soc_periph \
  --Mdir obj_dir -o tb_soc_periph \
  -f soc_periph.f

./obj_dir/tb_soc_periph > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

//--- sim/tb_soc_periph.sv
// ##########################################################
// peripheral subsystem testbench
// directed tests of the data memory, gpio block, cycle
// counter and unmapped decode through the data bus
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module tb_soc_periph;

  import pck_soc_bus::*;
  import pck_memory_map::*;

  localparam int SEED          = 32'h8429;
  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 10;
  localparam int NUM_MEM_WORDS = 16;
  localparam int XFER_CYCLES   = 4;                             // 3 per access plus slack
  localparam int NUM_XFERS     = 2*NUM_MEM_WORDS + 42 + 8 + 6 + 9 + 10;
  localparam int IDLE_CYCLES   = 2*4 + 22;                      // input settle and timer gaps
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + XFER_CYCLES*NUM_XFERS + IDLE_CYCLES + 32;

  logic  clk;
  logic  arst_n;
  addr_t dbus_addr;
  be_t   dbus_be;
  logic  dbus_wr_en;
  logic  dbus_rd_en;
  data_t dbus_wr_data;
  data_t dbus_rd_data;
  logic  busy;
  logic  ack;
  gpio_t gpio_in;
  gpio_t gpio_out;
  gpio_t gpio_oe;
  gpio_t gpio_pu;
  gpio_t gpio_pd;

  int    cycle_cnt = 0;
  int    req_cycle;                            // cycle of the last request edge
  int    data_errors = 0;
  int    gpio_errors = 0;
  int    bus_errors = 0;
  data_t mem_model [2**DMEM_DEPTH_PW2];

  soc_periph u_dut (
    .i_clk           ( clk          ),
    .i_arst_n        ( arst_n       ),
    .i_dbus_addr     ( dbus_addr    ),
    .i_dbus_be       ( dbus_be      ),
    .i_dbus_wr_en    ( dbus_wr_en   ),
    .i_dbus_wr_data  ( dbus_wr_data ),
    .i_dbus_rd_en    ( dbus_rd_en   ),
    .o_dbus_rd_data  ( dbus_rd_data ),
    .o_dbus_busy     ( busy         ),
    .o_dbus_ack      ( ack          ),
    .i_gpio_in       ( gpio_in      ),
    .o_gpio_out      ( gpio_out     ),
    .o_gpio_out_en   ( gpio_oe      ),
    .o_gpio_pullup   ( gpio_pu      ),
    .o_gpio_pulldown ( gpio_pd      )
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("run stopped by the timeout after %0d cycles", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic addr_t dmem_byte_addr(dmem_addr_t word);
    return DMEM_ADDR | addr_t'({word, 2'b00});
  endfunction

  function automatic addr_t reg_byte_addr(addr_t base, reg_addr_t ofs);
    return base | addr_t'({ofs, 2'b00});
  endfunction

  function automatic gpio_t pins_of_reg(reg_addr_t ofs);
    case (ofs)
      GPIO_OUT_OFS: return gpio_out;
      GPIO_OE_OFS:  return gpio_oe;
      GPIO_PU_OFS:  return gpio_pu;
      default:      return gpio_pd;
    endcase
  endfunction

  task automatic check_data(input string what, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      data_errors++;
    end
  endtask

  task automatic check_gpio(input string what, input gpio_t got, input gpio_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
      gpio_errors++;
    end
  endtask

  // ack is due in the cycle after the request edge
  task automatic wait_ack(input string what, output data_t rd_data);
    rd_data = '0;
    @(negedge clk);
    if (!ack) begin
      $display("the %s at %0t got no ack one cycle after its request", what, $time);
      bus_errors++;
    end else begin
      rd_data = dbus_rd_data;
      if (!busy) begin
        $display("busy was low during the ack of the %s at %0t", what, $time);
        bus_errors++;
      end
    end
    @(negedge clk);
    if (busy || ack) begin
      $display("the bus stayed busy after the %s at %0t", what, $time);
      bus_errors++;
    end
  endtask

  task automatic bus_write(input addr_t addr, input be_t be, input data_t data);
    data_t ignored;
    @(posedge clk);
    dbus_addr    <= addr;
    dbus_be      <= be;
    dbus_wr_data <= data;
    dbus_wr_en   <= 1'b1;
    @(posedge clk);                            // request edge
    req_cycle = cycle_cnt;
    dbus_wr_en <= 1'b0;
    wait_ack("write", ignored);
  endtask

  task automatic bus_read(input addr_t addr, output data_t data);
    @(posedge clk);
    dbus_addr  <= addr;
    dbus_be    <= 4'hF;
    dbus_rd_en <= 1'b1;
    @(posedge clk);
    req_cycle = cycle_cnt;
    dbus_rd_en <= 1'b0;
    wait_ack("read", data);
  endtask

  task automatic test_memory();
    dmem_addr_t words [NUM_MEM_WORDS];
    data_t      wdata;
    data_t      rd;
    for (int i = 0; i < NUM_MEM_WORDS; i++) begin
      words[i] = dmem_addr_t'($urandom);
      wdata = $urandom;
      mem_model[words[i]] = wdata;
      bus_write(dmem_byte_addr(words[i]), 4'hF, wdata);
    end
    for (int i = 0; i < NUM_MEM_WORDS; i++) begin
      bus_read(dmem_byte_addr(words[i]), rd);
      check_data("dmem word", rd, mem_model[words[i]]);
    end
  endtask

  task automatic test_byte_enables();
    dmem_addr_t word;
    data_t      patch;
    data_t      rd;
    be_t        be;
    for (int i = 1; i < 15; i++) begin
      be = be_t'(i);
      word = dmem_addr_t'($urandom);
      mem_model[word] = $urandom;
      patch = $urandom;
      bus_write(dmem_byte_addr(word), 4'hF, mem_model[word]);
      bus_write(dmem_byte_addr(word), be, patch);
      for (int lane = 0; lane < 4; lane++) begin
        if (be[lane]) mem_model[word][8*lane +: 8] = patch[8*lane +: 8];
      end
      bus_read(dmem_byte_addr(word), rd);
      check_data("dmem partial write", rd, mem_model[word]);
    end
  endtask

  task automatic test_gpio_outputs();
    reg_addr_t ofs;
    data_t     wdata;
    data_t     rd;
    for (int i = 0; i < 4; i++) begin
      ofs = (i == 0) ? GPIO_OUT_OFS : (i == 1) ? GPIO_OE_OFS :
            (i == 2) ? GPIO_PU_OFS : GPIO_PD_OFS;
      wdata = $urandom;
      bus_write(reg_byte_addr(GPIO_ADDR, ofs), 4'hF, wdata);
      check_gpio("gpio output pins", pins_of_reg(ofs), gpio_t'(wdata));
      bus_read(reg_byte_addr(GPIO_ADDR, ofs), rd);
      check_data("gpio register readback", rd, data_t'(gpio_t'(wdata)));
    end
  endtask

  task automatic test_gpio_input();
    gpio_t val;
    gpio_t out_before;
    data_t rd;
    for (int round = 0; round < 2; round++) begin
      val = gpio_t'($urandom);
      out_before = gpio_out;
      @(posedge clk);
      gpio_in <= val;
      repeat (3) @(posedge clk);               // longer than the synchronizer
      bus_read(reg_byte_addr(GPIO_ADDR, GPIO_IN_OFS), rd);
      check_data("gpio input", rd, data_t'(val));
      bus_write(reg_byte_addr(GPIO_ADDR, GPIO_IN_OFS), 4'hF, $urandom);
      bus_read(reg_byte_addr(GPIO_ADDR, GPIO_IN_OFS), rd);
      check_data("gpio input after write", rd, data_t'(val));
      check_gpio("gpio out after input write", gpio_out, out_before);
    end
  endtask

  task automatic test_cycle_counter();
    int    gaps [3] = '{0, 5, 17};
    int    first_cycle;
    data_t lo_first;
    data_t lo_second;
    data_t hi;
    for (int i = 0; i < 3; i++) begin
      bus_read(reg_byte_addr(TIMER_ADDR, TIMER_LO_OFS), lo_first);
      first_cycle = req_cycle;
      repeat (gaps[i]) @(posedge clk);
      bus_read(reg_byte_addr(TIMER_ADDR, TIMER_LO_OFS), lo_second);
      check_data("timer low delta", lo_second - lo_first, data_t'(req_cycle - first_cycle));
      bus_read(reg_byte_addr(TIMER_ADDR, TIMER_HI_OFS), hi);
      check_data("timer high word", hi, '0);
    end
  endtask

  task automatic test_unmapped();
    addr_t holes [4] = '{32'h4000_0000, 32'h1000_1000, 32'h2000_0100, 32'h3000_0100};
    gpio_t pins [4];
    data_t rd;
    mem_model[0] = $urandom;
    bus_write(dmem_byte_addr('0), 4'hF, mem_model[0]);   // 0x1000_1000 aliases word 0
    pins = '{gpio_out, gpio_oe, gpio_pu, gpio_pd};
    for (int i = 0; i < 4; i++) begin
      bus_read(holes[i], rd);
      check_data("unmapped read", rd, UNMAPPED_RD_DATA);
      bus_write(holes[i], 4'hF, $urandom);
    end
    bus_read(dmem_byte_addr('0), rd);
    check_data("dmem after unmapped write", rd, mem_model[0]);
    check_gpio("gpio out after unmapped write", gpio_out, pins[0]);
    check_gpio("gpio oe after unmapped write", gpio_oe, pins[1]);
    check_gpio("gpio pu after unmapped write", gpio_pu, pins[2]);
    check_gpio("gpio pd after unmapped write", gpio_pd, pins[3]);
  endtask

  initial begin
    void'($urandom(SEED));
    clk          = 1'b0;
    arst_n       = 1'b0;
    dbus_addr    = '0;
    dbus_be      = '0;
    dbus_wr_en   = 1'b0;
    dbus_rd_en   = 1'b0;
    dbus_wr_data = '0;
    gpio_in      = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    if (busy || ack) begin
      $display("busy or ack was high right after reset");
      bus_errors++;
    end
    check_gpio("gpio out after reset", gpio_out, '0);
    check_gpio("gpio oe after reset", gpio_oe, '0);
    check_gpio("gpio pu after reset", gpio_pu, '0);
    check_gpio("gpio pd after reset", gpio_pd, '0);
    test_memory();
    test_byte_enables();
    test_gpio_outputs();
    test_gpio_input();
    test_cycle_counter();
    test_unmapped();
    $display("errors: data %0d, gpio %0d, bus %0d", data_errors, gpio_errors, bus_errors);
    if (data_errors + gpio_errors + bus_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- soc_periph.f
design/pck_soc_bus.sv
design/pck_memory_map.sv
design/soc_bridge.sv
design/soc_cycle_counter.sv
design/soc_dmem.sv
design/perif_gpio.sv
design/soc_periph.sv
sim/tb_soc_periph.sv
